// ==== tb.f ====
+incdir+tests
verilog/intr_pkg.sv
verilog/intr_edge_capture.sv
verilog/intr_apb_regs.sv
verilog/intr_irq_seq.sv
verilog/intr_handler_top.sv
tests/tb_intr_handler.sv

// ==== tests/tb_apb_tasks.svh ====
////////////////////////////////////////////////////////////
// Stimulus table entry layout and APB master tasks
////////////////////////////////////////////////////////////

`ifndef TB_APB_TASKS_SVH
`define TB_APB_TASKS_SVH

// Table operations
typedef enum {
   OP_WR,    // APB write, expect pslverr
   OP_RD,    // APB read, expect prdata and pslverr
   OP_C2H,   // Set c2h lines
   OP_ERR,   // Set err_in
   OP_ACK,   // One-cycle irq_ack pulse
   OP_IRQ,   // Wait for irq_out to reach a level, then hold it
   OP_H2C    // Check h2c_intr_out on the next cycle
} op_t;

typedef struct {
   op_t                   op;
   logic [APB_ADDR_W-1:0] addr;
   logic [127:0]          value;    // Write data or line levels
   logic [127:0]          expv;
   logic                  exp_err;  // Expected pslverr
   string                 name;
} entry_t;

// Setup phase, access phase, back to idle on the edge that ends the transfer
task automatic write_reg(input logic [APB_ADDR_W-1:0] addr, input logic [APB_DATA_W-1:0] data,
                         output logic err, output logic rdy);
   @(posedge clk);
   psel    <= 1'b1;
   penable <= 1'b0;
   pwrite  <= 1'b1;
   paddr   <= addr;
   pwdata  <= data;
   @(posedge clk);
   penable <= 1'b1;
   @(negedge clk);
   rdy = pready;   // Access phase response
   err = pslverr;
   @(posedge clk);
   psel    <= 1'b0;
   penable <= 1'b0;
   pwrite  <= 1'b0;
endtask

task automatic read_reg(input logic [APB_ADDR_W-1:0] addr, output logic [APB_DATA_W-1:0] data,
                        output logic err, output logic rdy);
   @(posedge clk);
   psel    <= 1'b1;
   penable <= 1'b0;
   pwrite  <= 1'b0;
   paddr   <= addr;
   @(posedge clk);
   penable <= 1'b1;
   @(negedge clk);
   rdy  = pready;
   data = prdata;
   err  = pslverr;
   @(posedge clk);
   psel    <= 1'b0;
   penable <= 1'b0;
endtask

`endif

// ==== tests/tb_intr_handler.sv ====
////////////////////////////////////////////////////////////
// Interrupt handler testbench
// Clock, reset, stimulus table, apply loop, checks and timeout
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_intr_handler;

   import intr_pkg::*;

   logic                   clk;
   logic                   resetn;
   logic [APB_ADDR_W-1:0]  paddr;
   logic                   psel;
   logic                   penable;
   logic                   pwrite;
   logic [APB_DATA_W-1:0]  pwdata;
   logic [APB_DATA_W-1:0]  prdata;
   logic                   pready;
   logic                   pslverr;
   logic [NUM_C2H_DEF-1:0] c2h_intr_in;
   logic [NUM_ERR_DEF-1:0] err_in;
   logic [NUM_H2C_DEF-1:0] h2c_intr_out;
   logic                   irq_out;
   logic                   irq_ack;

   integer      seed = 32'h3210908d;
   int          n_pass = 0;
   int          n_fail = 0;
   int          cycles = 0;
   int          max_cycles = 0;
   logic [63:0] lines_m;    // Model of the c2h lines
   logic [63:0] status_m;   // Expected toggle status

   `include "tb_apb_tasks.svh"

   entry_t tbl[$];

   intr_handler_top uut (
      .clk          (clk),
      .resetn       (resetn),
      .paddr        (paddr),
      .psel         (psel),
      .penable      (penable),
      .pwrite       (pwrite),
      .pwdata       (pwdata),
      .prdata       (prdata),
      .pready       (pready),
      .pslverr      (pslverr),
      .c2h_intr_in  (c2h_intr_in),
      .err_in       (err_in),
      .h2c_intr_out (h2c_intr_out),
      .irq_out      (irq_out),
      .irq_ack      (irq_ack)
   );

   initial
   begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   // Run limit, set from the table length once the table is built
   always @(posedge clk)
   begin
      cycles <= cycles + 1;
      if ((max_cycles > 0) && (cycles >= max_cycles))
      begin
         $display("Run did not finish the test table within %0d cycles", max_cycles);
         $display("TESTBENCH FAILED");
         $finish;
      end
   end

   task automatic add_entry(input op_t op, input logic [APB_ADDR_W-1:0] addr,
                            input logic [127:0] value, input logic [127:0] expv,
                            input logic exp_err, input string name);
      entry_t e;
      e.op      = op;
      e.addr    = addr;
      e.value   = value;
      e.expv    = expv;
      e.exp_err = exp_err;
      e.name    = name;
      tbl.push_back(e);
   endtask

   // Either edge on a line sets its status bit
   task automatic drive_lines(input logic [63:0] v, input string name);
      add_entry(OP_C2H, '0, v, '0, 1'b0, name);
      status_m = status_m | (lines_m ^ v);
      lines_m  = v;
   endtask

   task automatic clear_status(input int word, input logic [31:0] mask, input string name);
      add_entry(OP_WR, ADDR_TOGGLE_CLEAR + 4 * word, mask, '0, 1'b0, name);
      status_m = status_m & ~({32'h0, mask} << (32 * word));
   endtask

   task automatic expect_pair(input logic [APB_ADDR_W-1:0] addr, input logic [63:0] v,
                              input string name);
      add_entry(OP_RD, addr, '0, v[31:0], 1'b0, {name, "_w0"});
      add_entry(OP_RD, addr + 4, '0, v[63:32], 1'b0, {name, "_w1"});
   endtask

   task automatic check_value(input string name, input string what,
                              input logic [127:0] expv, input logic [127:0] actv);
      if (actv === expv)
      begin
         n_pass++;
         $display("PASS  %s", name);
      end
      else
      begin
         n_fail++;
         $display("ERROR %s: %s expected %0h, actual %0h", name, what, expv, actv);
      end
   endtask

   // Wait up to 8 cycles for the level, then require it to hold for 4
   task automatic wait_irq(input logic expv, output logic actv);
      int n;
      n    = 0;
      actv = ~expv;
      while ((n < 8) && (actv !== expv))
      begin
         @(negedge clk);
         actv = irq_out;
         n++;
      end
      n = 0;
      while ((n < 4) && (actv === expv))
      begin
         @(negedge clk);
         actv = irq_out;
         n++;
      end
   endtask

   task automatic build_table();
      logic [127:0] h2c_words;
      logic [63:0]  pattern;
      logic [63:0]  mask;
      lines_m   = '0;
      status_m  = '0;
      h2c_words = {$random(seed), $random(seed), $random(seed), $random(seed)};
      pattern   = {$random(seed), $random(seed)};
      mask      = {$random(seed), $random(seed)};

      add_entry(OP_IRQ, '0, '0, '0, 1'b0, "reset_irq_low");
      add_entry(OP_H2C, '0, '0, '0, 1'b0, "reset_h2c_zero");
      add_entry(OP_RD, ADDR_VERSION, '0, INTR_VERSION, 1'b0, "version_read");
      expect_pair(ADDR_TOGGLE_ENABLE, '0, "toggle_enable_reset");
      add_entry(OP_RD, ADDR_ERR_ENABLE, '0, '0, 1'b0, "err_enable_reset");

      for (int k = 0; k < 4; k++)
         add_entry(OP_WR, ADDR_H2C_INTR + 4 * k, h2c_words[32*k +: 32], '0, 1'b0,
                   $sformatf("h2c_write_w%0d", k));
      add_entry(OP_H2C, '0, '0, h2c_words, 1'b0, "h2c_output");
      for (int k = 0; k < 4; k++)
         add_entry(OP_RD, ADDR_H2C_INTR + 4 * k, '0, h2c_words[32*k +: 32], 1'b0,
                   $sformatf("h2c_readback_w%0d", k));

      // Random pattern with all enables still off
      drive_lines(pattern, "c2h_pattern");
      expect_pair(ADDR_C2H_STATUS, lines_m, "c2h_level");
      expect_pair(ADDR_TOGGLE_STATUS, status_m, "status_after_pattern");
      drive_lines('0, "c2h_return");
      expect_pair(ADDR_TOGGLE_STATUS, status_m, "status_sticky");
      clear_status(0, mask[31:0], "clear_part_w0");
      clear_status(1, mask[63:32], "clear_part_w1");
      expect_pair(ADDR_TOGGLE_STATUS, status_m, "status_part_clear");
      clear_status(0, 32'hffff_ffff, "clear_all_w0");
      clear_status(1, 32'hffff_ffff, "clear_all_w1");
      expect_pair(ADDR_TOGGLE_STATUS, status_m, "status_all_clear");

      // Request/ack sequence on c2h bit 0
      add_entry(OP_WR, ADDR_TOGGLE_ENABLE, 32'h1, '0, 1'b0, "enable_bit0");
      drive_lines(64'h1, "c2h_bit0_rise");
      add_entry(OP_IRQ, '0, '0, 1, 1'b0, "irq_raised");
      add_entry(OP_ACK, '0, '0, '0, 1'b0, "first_ack");
      add_entry(OP_IRQ, '0, '0, 1, 1'b0, "irq_held_after_ack");
      clear_status(0, 32'h1, "clear_bit0");
      add_entry(OP_IRQ, '0, '0, 0, 1'b0, "irq_dropped");
      add_entry(OP_ACK, '0, '0, '0, 1'b0, "second_ack");
      drive_lines(64'h0, "c2h_bit0_fall");
      add_entry(OP_IRQ, '0, '0, 1, 1'b0, "irq_raised_again");
      add_entry(OP_ACK, '0, '0, '0, 1'b0, "first_ack_again");
      clear_status(0, 32'h1, "clear_bit0_again");
      add_entry(OP_IRQ, '0, '0, 0, 1'b0, "irq_dropped_again");
      add_entry(OP_ACK, '0, '0, '0, 1'b0, "second_ack_again");
      drive_lines(64'h0000_0100_0000_0020, "c2h_disabled_bits");
      add_entry(OP_IRQ, '0, '0, 0, 1'b0, "disabled_no_irq");
      expect_pair(ADDR_TOGGLE_STATUS, status_m, "status_disabled_bits");

      // Error inputs, only bit 2 enabled
      add_entry(OP_WR, ADDR_ERR_ENABLE, 32'h4, '0, 1'b0, "err_enable_bit2");
      add_entry(OP_RD, ADDR_ERR_ENABLE, '0, 32'h4, 1'b0, "err_enable_readback");
      add_entry(OP_ERR, '0, 32'h8, '0, 1'b0, "err_bit3_set");
      add_entry(OP_IRQ, '0, '0, 0, 1'b0, "err_disabled_no_irq");
      add_entry(OP_ERR, '0, 32'hc, '0, 1'b0, "err_bit2_set");
      add_entry(OP_IRQ, '0, '0, 1, 1'b0, "err_irq_raised");
      add_entry(OP_ACK, '0, '0, '0, 1'b0, "err_first_ack");
      add_entry(OP_ERR, '0, 32'h0, '0, 1'b0, "err_cleared");
      add_entry(OP_IRQ, '0, '0, 0, 1'b0, "err_irq_dropped");
      add_entry(OP_ACK, '0, '0, '0, 1'b0, "err_second_ack");

      add_entry(OP_RD, 12'h070, '0, '0, 1'b1, "unmapped_read");
      add_entry(OP_WR, ADDR_VERSION, 32'hdead_beef, '0, 1'b1, "version_write_rejected");
      add_entry(OP_RD, ADDR_VERSION, '0, INTR_VERSION, 1'b0, "version_unchanged");
   endtask

   initial
   begin
      entry_t                e;
      logic [APB_DATA_W-1:0] rdata;
      logic                  err;
      logic                  rdy;
      logic                  irq_seen;
      resetn      = 1'b0;
      paddr       = '0;
      psel        = 1'b0;
      penable     = 1'b0;
      pwrite      = 1'b0;
      pwdata      = '0;
      c2h_intr_in = '0;
      err_in      = '0;
      irq_ack     = 1'b0;
      build_table();
      max_cycles = tbl.size() * 20 + 10;   // 10 reset cycles
      repeat (10) @(posedge clk);
      resetn <= 1'b1;

      for (int i = 0; i < tbl.size(); i++)
      begin
         e = tbl[i];
         case (e.op)
            OP_WR:
            begin
               write_reg(e.addr, e.value[APB_DATA_W-1:0], err, rdy);
               if (rdy !== 1'b1)
                  check_value(e.name, "pready", 1'b1, rdy);
               else
                  check_value(e.name, "pslverr", e.exp_err, err);
            end
            OP_RD:
            begin
               read_reg(e.addr, rdata, err, rdy);
               if (rdy !== 1'b1)
                  check_value(e.name, "pready", 1'b1, rdy);
               else if (err !== e.exp_err)
                  check_value(e.name, "pslverr", e.exp_err, err);
               else
                  check_value(e.name, "prdata", e.expv, rdata);
            end
            OP_C2H:
            begin
               @(posedge clk);
               c2h_intr_in <= e.value[NUM_C2H_DEF-1:0];
               @(posedge clk);   // Captured at this edge
            end
            OP_ERR:
            begin
               @(posedge clk);
               err_in <= e.value[NUM_ERR_DEF-1:0];
               @(posedge clk);
            end
            OP_ACK:
            begin
               @(posedge clk);
               irq_ack <= 1'b1;
               @(posedge clk);
               irq_ack <= 1'b0;
            end
            OP_IRQ:
            begin
               wait_irq(e.expv[0], irq_seen);
               check_value(e.name, "irq_out", e.expv[0], irq_seen);
            end
            OP_H2C:
            begin
               @(posedge clk);   // Output trails the register by one cycle
               @(negedge clk);
               check_value(e.name, "h2c_intr_out", e.expv, h2c_intr_out);
            end
            default:
            begin
               n_fail++;
               $display("Table entry %0d has an unknown operation", i);
            end
         endcase
      end

      $display("Tests finished: %0d passed, %0d failed", n_pass, n_fail);
      if (n_fail == 0)
         $display("TESTBENCH PASSED");
      else
         $display("TESTBENCH FAILED");
      $finish;
   end

endmodule

// ==== verilog/intr_apb_regs.sv ====
////////////////////////////////////////////////////////////
// APB register file for the interrupt handler
// Enables, h2c words, clear strobes, read-back and slave error
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module intr_apb_regs #(
   parameter int NUM_C2H = intr_pkg::NUM_C2H_DEF,
   parameter int NUM_H2C = intr_pkg::NUM_H2C_DEF,
   parameter int NUM_ERR = intr_pkg::NUM_ERR_DEF
) (
   input  logic                            clk,
   input  logic                            resetn,
   input  logic [intr_pkg::APB_ADDR_W-1:0] paddr,
   input  logic                            psel,
   input  logic                            penable,
   input  logic                            pwrite,
   input  logic [intr_pkg::APB_DATA_W-1:0] pwdata,
   output logic [intr_pkg::APB_DATA_W-1:0] prdata,
   output logic                            pready,
   output logic                            pslverr,
   input  logic [NUM_C2H-1:0]              c2h_level,
   input  logic [NUM_C2H-1:0]              toggle_status,
   output logic [NUM_C2H-1:0]              toggle_clear,
   output logic [NUM_C2H-1:0]              toggle_enable,
   output logic [NUM_ERR-1:0]              err_enable,
   output logic [NUM_H2C-1:0]              h2c_intr_out
);

   import intr_pkg::*;

   localparam int C2H_WORDS = NUM_C2H / APB_DATA_W;
   localparam int H2C_WORDS = NUM_H2C / APB_DATA_W;

   logic [APB_ADDR_W-5:0] blk;   // Block select, 16 bytes per block
   logic [1:0]            wrd;   // Word inside the block
   logic                  aligned;
   logic                  hit_version;
   logic                  hit_c2h_stat;
   logic                  hit_tog_stat;
   logic                  hit_tog_en;
   logic                  hit_tog_clr;
   logic                  hit_h2c;
   logic                  hit_err_en;
   logic                  hit_ro;
   logic                  hit_any;
   logic                  access;
   logic                  bad_access;
   logic                  wr_en;
   logic [NUM_H2C-1:0]    h2c_reg;

   assign blk     = paddr[APB_ADDR_W-1:4];
   assign wrd     = paddr[3:2];
   assign aligned = (paddr[1:0] == 2'b00);

   // Address decode, words past the configured count do not exist
   assign hit_version  = (blk == ADDR_VERSION[APB_ADDR_W-1:4]) && (wrd == 2'd0);
   assign hit_c2h_stat = (blk == ADDR_C2H_STATUS[APB_ADDR_W-1:4]) && (wrd < C2H_WORDS);
   assign hit_tog_stat = (blk == ADDR_TOGGLE_STATUS[APB_ADDR_W-1:4]) && (wrd < C2H_WORDS);
   assign hit_tog_en   = (blk == ADDR_TOGGLE_ENABLE[APB_ADDR_W-1:4]) && (wrd < C2H_WORDS);
   assign hit_tog_clr  = (blk == ADDR_TOGGLE_CLEAR[APB_ADDR_W-1:4]) && (wrd < C2H_WORDS);
   assign hit_h2c      = (blk == ADDR_H2C_INTR[APB_ADDR_W-1:4]) && (wrd < H2C_WORDS);
   assign hit_err_en   = (blk == ADDR_ERR_ENABLE[APB_ADDR_W-1:4]) && (wrd == 2'd0);

   assign hit_ro  = hit_version | hit_c2h_stat | hit_tog_stat;
   assign hit_any = aligned & (hit_ro | hit_tog_en | hit_tog_clr | hit_h2c | hit_err_en);

   // No wait states, every transfer completes in its access phase
   assign pready     = 1'b1;
   assign access     = psel & penable;
   assign bad_access = !hit_any || (pwrite && hit_ro);
   assign pslverr    = access & bad_access;
   assign wr_en      = access & pwrite & ~bad_access;  // Bad writes change nothing

   // Host writable registers
   always_ff @(posedge clk)
   begin
      if (!resetn)
      begin
         toggle_enable <= '0;
         h2c_reg       <= '0;
         err_enable    <= '0;
      end
      else if (wr_en)
      begin
         for (int k = 0; k < C2H_WORDS; k++)
         begin
            if (hit_tog_en && (wrd == k))
               toggle_enable[k*APB_DATA_W +: APB_DATA_W] <= pwdata;
         end
         for (int k = 0; k < H2C_WORDS; k++)
         begin
            if (hit_h2c && (wrd == k))
               h2c_reg[k*APB_DATA_W +: APB_DATA_W] <= pwdata;
         end
         if (hit_err_en)
            err_enable <= pwdata[NUM_ERR-1:0];
      end
   end

   // h2c output trails the register by one cycle
   always_ff @(posedge clk)
   begin
      if (!resetn)
         h2c_intr_out <= '0;
      else
         h2c_intr_out <= h2c_reg;
   end

   // Write-one-to-clear strobes, live only during the access phase
   always_comb
   begin
      toggle_clear = '0;
      if (wr_en && hit_tog_clr)
      begin
         for (int k = 0; k < C2H_WORDS; k++)
         begin
            if (wrd == k)
               toggle_clear[k*APB_DATA_W +: APB_DATA_W] = pwdata;
         end
      end
   end

   // Read mux
   always_comb
   begin
      prdata = '0;                   // Clear block and misses read zero
      if (hit_version)
         prdata = INTR_VERSION;
      if (hit_err_en)
         prdata[NUM_ERR-1:0] = err_enable;
      for (int k = 0; k < C2H_WORDS; k++)
      begin
         if (wrd == k)
         begin
            if (hit_c2h_stat)
               prdata = c2h_level[k*APB_DATA_W +: APB_DATA_W];
            if (hit_tog_stat)
               prdata = toggle_status[k*APB_DATA_W +: APB_DATA_W];
            if (hit_tog_en)
               prdata = toggle_enable[k*APB_DATA_W +: APB_DATA_W];
         end
      end
      for (int k = 0; k < H2C_WORDS; k++)
      begin
         if (hit_h2c && (wrd == k))
            prdata = h2c_reg[k*APB_DATA_W +: APB_DATA_W];
      end
   end

endmodule

// ==== verilog/intr_edge_capture.sv ====
////////////////////////////////////////////////////////////
// c2h interrupt capture stage
// Input register, either-edge detect and sticky toggle status
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module intr_edge_capture #(
   parameter int NUM_C2H = intr_pkg::NUM_C2H_DEF
) (
   input  logic               clk,
   input  logic               resetn,
   input  logic [NUM_C2H-1:0] c2h_intr_in,
   input  logic [NUM_C2H-1:0] toggle_clear,   // One-cycle strobe from the host
   output logic [NUM_C2H-1:0] c2h_level,
   output logic [NUM_C2H-1:0] toggle_status
);

   logic [NUM_C2H-1:0] c2h_edge;

   // Raw line differs from the registered copy on a rising or falling edge
   assign c2h_edge = c2h_intr_in ^ c2h_level;

   // Registered level, also read back by the host
   always_ff @(posedge clk)
   begin
      if (!resetn)
      begin
         c2h_level <= '0;
      end
      else
      begin
         c2h_level <= c2h_intr_in;
      end
   end

   // Sticky toggle status
   // A clear bit picks up any edge, a set bit only drops on its clear strobe
   always_ff @(posedge clk)
   begin
      if (!resetn)
      begin
         toggle_status <= '0;
      end
      else
      begin
         for (int i = 0; i < NUM_C2H; i++)
         begin
            if (!toggle_status[i])
            begin
               toggle_status[i] <= c2h_edge[i];
            end
            else if (toggle_clear[i])
            begin
               toggle_status[i] <= 1'b0;   // Edge in this cycle is dropped
            end
         end
      end
   end

endmodule

// ==== verilog/intr_handler_top.sv ====
////////////////////////////////////////////////////////////
// Interrupt handler top level
// Edge capture, APB register file and request sequencer
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module intr_handler_top #(
   parameter int NUM_C2H = intr_pkg::NUM_C2H_DEF,
   parameter int NUM_H2C = intr_pkg::NUM_H2C_DEF,
   parameter int NUM_ERR = intr_pkg::NUM_ERR_DEF
) (
   input  logic                            clk,
   input  logic                            resetn,

   // APB slave
   input  logic [intr_pkg::APB_ADDR_W-1:0] paddr,
   input  logic                            psel,
   input  logic                            penable,
   input  logic                            pwrite,
   input  logic [intr_pkg::APB_DATA_W-1:0] pwdata,
   output logic [intr_pkg::APB_DATA_W-1:0] prdata,
   output logic                            pready,
   output logic                            pslverr,

   // Card side
   input  logic [NUM_C2H-1:0]              c2h_intr_in,
   input  logic [NUM_ERR-1:0]              err_in,
   output logic [NUM_H2C-1:0]              h2c_intr_out,

   // Host request/ack pair
   output logic                            irq_out,
   input  logic                            irq_ack
);

   logic [NUM_C2H-1:0] c2h_level;
   logic [NUM_C2H-1:0] toggle_status;
   logic [NUM_C2H-1:0] toggle_clear;
   logic [NUM_C2H-1:0] toggle_enable;
   logic [NUM_ERR-1:0] err_enable;

   intr_edge_capture #(
      .NUM_C2H (NUM_C2H)
   ) u_edge_capture (
      .clk           (clk),
      .resetn        (resetn),
      .c2h_intr_in   (c2h_intr_in),
      .toggle_clear  (toggle_clear),
      .c2h_level     (c2h_level),
      .toggle_status (toggle_status)
   );

   intr_apb_regs #(
      .NUM_C2H (NUM_C2H),
      .NUM_H2C (NUM_H2C),
      .NUM_ERR (NUM_ERR)
   ) u_apb_regs (
      .clk           (clk),
      .resetn        (resetn),
      .paddr         (paddr),
      .psel          (psel),
      .penable       (penable),
      .pwrite        (pwrite),
      .pwdata        (pwdata),
      .prdata        (prdata),
      .pready        (pready),
      .pslverr       (pslverr),
      .c2h_level     (c2h_level),
      .toggle_status (toggle_status),
      .toggle_clear  (toggle_clear),
      .toggle_enable (toggle_enable),
      .err_enable    (err_enable),
      .h2c_intr_out  (h2c_intr_out)
   );

   intr_irq_seq #(
      .NUM_C2H (NUM_C2H),
      .NUM_ERR (NUM_ERR)
   ) u_irq_seq (
      .clk           (clk),
      .resetn        (resetn),
      .toggle_status (toggle_status),
      .toggle_enable (toggle_enable),
      .err_in        (err_in),
      .err_enable    (err_enable),
      .irq_ack       (irq_ack),
      .irq_out       (irq_out)
   );

endmodule

// ==== verilog/intr_irq_seq.sv ====
////////////////////////////////////////////////////////////
// Host interrupt request sequencer
// Pending reduction and four-state request/ack handshake
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module intr_irq_seq #(
   parameter int NUM_C2H = intr_pkg::NUM_C2H_DEF,
   parameter int NUM_ERR = intr_pkg::NUM_ERR_DEF
) (
   input  logic               clk,
   input  logic               resetn,
   input  logic [NUM_C2H-1:0] toggle_status,
   input  logic [NUM_C2H-1:0] toggle_enable,
   input  logic [NUM_ERR-1:0] err_in,
   input  logic [NUM_ERR-1:0] err_enable,
   input  logic               irq_ack,
   output logic               irq_out
);

   import intr_pkg::*;

   irq_state_t state;
   irq_state_t state_nxt;
   logic       c2h_pending;
   logic       err_pending;
   logic       pending;

   assign c2h_pending = |(toggle_status & toggle_enable);
   assign err_pending = |(err_in & err_enable);   // Error inputs are levels
   assign pending     = c2h_pending | err_pending;

   always_ff @(posedge clk)
   begin
      if (!resetn)
         state <= IRQ_IDLE;
      else
         state <= state_nxt;
   end

   // Host acks once to take the request and again after it drops
   always_comb
   begin
      state_nxt = state;
      case (state)
         IRQ_IDLE:
         begin
            if (pending)
               state_nxt = IRQ_ASSERT;
         end
         IRQ_ASSERT:
         begin
            if (irq_ack)
               state_nxt = IRQ_ACKED;
         end
         IRQ_ACKED:
         begin
            if (!pending)
               state_nxt = IRQ_RELEASE;   // Host has serviced every source
         end
         IRQ_RELEASE:
         begin
            if (irq_ack)
               state_nxt = IRQ_IDLE;
         end
         default:
         begin
            state_nxt = IRQ_IDLE;
         end
      endcase
   end

   assign irq_out = (state == IRQ_ASSERT) || (state == IRQ_ACKED);

endmodule

// ==== verilog/intr_pkg.sv ====
////////////////////////////////////////////////////////////
// Interrupt handler shared definitions
// Bus widths, default line counts, APB register map, version
// and the request sequencer state type
////////////////////////////////////////////////////////////

package intr_pkg;

   // APB bus
   localparam int APB_ADDR_W = 12;
   localparam int APB_DATA_W = 32;

   localparam logic [APB_DATA_W-1:0] INTR_VERSION = 32'h0001_0200;  // Major 1, minor 2

   // Default line counts
   // Each count is a multiple of 32 and at most 128 so it fits one block
   localparam int NUM_C2H_DEF = 64;
   localparam int NUM_H2C_DEF = 128;
   localparam int NUM_ERR_DEF = 32;

   // Register map
   // Byte address of word 0 of each block, word k sits at offset + 4*k
   localparam logic [APB_ADDR_W-1:0] ADDR_VERSION       = 12'h000;  // RO
   localparam logic [APB_ADDR_W-1:0] ADDR_C2H_STATUS    = 12'h010;  // RO, live c2h level
   localparam logic [APB_ADDR_W-1:0] ADDR_TOGGLE_STATUS = 12'h020;  // RO
   localparam logic [APB_ADDR_W-1:0] ADDR_TOGGLE_ENABLE = 12'h030;  // RW
   localparam logic [APB_ADDR_W-1:0] ADDR_TOGGLE_CLEAR  = 12'h040;  // W1C, reads zero
   localparam logic [APB_ADDR_W-1:0] ADDR_H2C_INTR      = 12'h050;  // RW
   localparam logic [APB_ADDR_W-1:0] ADDR_ERR_ENABLE    = 12'h060;  // RW, single word

   // Host request sequencer
   typedef enum logic [1:0] {
      IRQ_IDLE    = 2'b00,  // Nothing pending
      IRQ_ASSERT  = 2'b01,  // Request raised, waiting for first ack
      IRQ_ACKED   = 2'b10,  // Host acked, waiting for sources to drain
      IRQ_RELEASE = 2'b11   // Request dropped, waiting for second ack
   } irq_state_t;

endpackage
